// ==== Makefile ====
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard tb/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+tb
verilog/icache_cfg_pkg.sv
verilog/icache_msg_pkg.sv
verilog/icache_sram.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_replacement.sv
verilog/icache_lookup.sv
verilog/icache_miss_ctrl.sv
verilog/icache_top.sv
tb/icache_tb.sv

// ==== tb/icache_tb_ref.svh ====
/*
 * icache testbench reference model
 * Line contents, a valid-bit and pseudo-LRU model per set,
 * and the compare tasks used by the checker.
 */
`ifndef ICACHE_TB_REF_SVH
`define ICACHE_TB_REF_SVH

int check_count = 0;
int error_count = 0;

icache_cfg_pkg::ways_t model_valid [icache_cfg_pkg::sets_lp];
icache_cfg_pkg::tag_t  model_tag   [icache_cfg_pkg::sets_lp][icache_cfg_pkg::ways_lp];
icache_cfg_pkg::lru_t  model_lru   [icache_cfg_pkg::sets_lp];

// fixed hash of line address and word offset
function automatic icache_cfg_pkg::dword_t ref_word(input icache_cfg_pkg::addr_t line_addr,
                                                    input icache_cfg_pkg::word_offset_t offset);
  logic [31:0] h;
  h = line_addr | {26'd0, offset, 3'd0};
  h = h * 32'h9e3779b1;
  return {h ^ 32'hc2b2ae35, h[15:0], h[31:16]};
endfunction

// bit 2 of the address picks the upper half of the word
function automatic icache_cfg_pkg::instr_t ref_instr(input icache_cfg_pkg::addr_t addr);
  icache_cfg_pkg::dword_t word;
  word = ref_word({addr[31:6], 6'd0}, addr[5:3]);
  return addr[2] ? word[63:32] : word[31:0];
endfunction

// point the path of the hit way at its sibling
function automatic icache_cfg_pkg::lru_t ref_lru_hit(input icache_cfg_pkg::lru_t lru,
                                                     input icache_cfg_pkg::way_id_t way);
  icache_cfg_pkg::lru_t next;
  next = lru;
  if (way < 2'd2) begin
    next[0] = 1'b1;
    next[1] = (way == 2'd0);
  end else begin
    next[0] = 1'b0;
    next[2] = (way == 2'd2);
  end
  return next;
endfunction

function automatic icache_cfg_pkg::way_id_t ref_victim(input icache_cfg_pkg::ways_t valid,
                                                       input icache_cfg_pkg::lru_t lru);
  icache_cfg_pkg::way_id_t victim;
  logic found;
  found = 1'b0;
  victim = '0;
  for (int w = 0; w < icache_cfg_pkg::ways_lp; w++) begin
    if (!valid[w] && !found) begin
      victim = icache_cfg_pkg::way_id_t'(w);
      found = 1'b1;
    end
  end
  if (!found) begin
    // walk the tree from the root
    if (lru[0]) begin
      victim = lru[2] ? 2'd3 : 2'd2;
    end else begin
      victim = lru[1] ? 2'd1 : 2'd0;
    end
  end
  return victim;
endfunction

task automatic report_failure(input string msg);
  error_count++;
  $display("%s: %s", test_name, msg);
endtask

task automatic check_instr(input string what, input icache_cfg_pkg::instr_t exp,
                           input icache_cfg_pkg::instr_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_way(input string what, input icache_cfg_pkg::way_id_t exp,
                         input icache_cfg_pkg::way_id_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
  end
endtask

task automatic check_addr(input string what, input icache_cfg_pkg::addr_t exp,
                          input icache_cfg_pkg::addr_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
  end
endtask

`endif

// ==== tb/icache_tb.sv ====
/*
 * icache testbench
 * Drives fetches and fill commands into icache_top, serves misses
 * and checks every result against a reference model of the cache.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

  localparam int fetch_count_lp = 32;
  localparam int cycle_limit_lp = fetch_count_lp * 40;

  logic                         clk_i;
  logic                         reset_i;
  icache_cfg_pkg::addr_t        addr_i;
  logic                         addr_v_i;
  logic                         addr_ready_o;
  icache_cfg_pkg::instr_t       data_o;
  logic                         data_v_o;
  logic                         miss_o;
  icache_cfg_pkg::addr_t        miss_req_addr_o;
  icache_cfg_pkg::way_id_t      miss_req_way_o;
  logic                         miss_req_v_o;
  logic                         miss_req_ready_i;
  logic                         fill_v_i;
  icache_msg_pkg::fill_op_e     fill_op_i;
  icache_cfg_pkg::index_t       fill_index_i;
  icache_cfg_pkg::way_id_t      fill_way_i;
  icache_cfg_pkg::word_offset_t fill_offset_i;
  icache_cfg_pkg::tag_t         fill_tag_i;
  icache_cfg_pkg::dword_t       fill_data_i;
  logic                         fill_ready_o;
  logic                         fill_done_i;

  integer                seed;
  string                 test_name;
  icache_cfg_pkg::addr_t line_addr [9];
  icache_cfg_pkg::addr_t set_addr [5];

  // expected pipeline and miss state
  logic                    tl_v;
  logic                    tl_hit;
  icache_cfg_pkg::way_id_t tl_way;
  icache_cfg_pkg::ways_t   tl_valid;
  icache_cfg_pkg::addr_t   tl_addr;
  logic                    tv_v;
  logic                    tv_hit;
  icache_cfg_pkg::way_id_t tv_way;
  icache_cfg_pkg::ways_t   tv_valid;
  icache_cfg_pkg::addr_t   tv_addr;
  logic                    tracker_m;
  logic                    req_pend;
  icache_cfg_pkg::addr_t   req_addr;
  icache_cfg_pkg::way_id_t req_way;
  logic                    tv_miss_m;
  logic                    ready_m;
  logic                    accept_m;
  icache_cfg_pkg::index_t  tv_idx;
  icache_cfg_pkg::index_t  tl_idx;

  `include "icache_tb_ref.svh"

  icache_top icache_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      tl_v      = 1'b0;
      tv_v      = 1'b0;
      tracker_m = 1'b0;
      req_pend  = 1'b0;
      for (int s = 0; s < icache_cfg_pkg::sets_lp; s++) begin
        model_lru[s] = '0;
      end
    end else begin
      // request holds valid and values until taken
      check_flag("request valid", req_pend, miss_req_v_o);
      if (req_pend) begin
        check_addr("request address", req_addr, miss_req_addr_o);
        check_way("request way", req_way, miss_req_way_o);
        if (miss_req_ready_i) begin
          req_pend = 1'b0;
        end
      end
      tv_miss_m = tv_v & ~tv_hit;
      tv_idx    = tv_addr[11:6];
      check_flag("data valid", tv_v & tv_hit, data_v_o);
      check_flag("miss", tv_miss_m, miss_o);
      if (tv_v && tv_hit) begin
        check_instr("instruction", ref_instr(tv_addr), data_o);
        model_lru[tv_idx] = ref_lru_hit(model_lru[tv_idx], tv_way);
      end
      if (tv_miss_m) begin
        req_pend = 1'b1;
        req_addr = {tv_addr[31:6], 6'd0};
        req_way  = ref_victim(tv_valid, model_lru[tv_idx]);
      end
      ready_m  = ~tracker_m & ~tv_miss_m;
      accept_m = addr_v_i & ready_m;
      check_flag("fetch ready", ready_m, addr_ready_o);
      check_flag("fill ready", ~accept_m, fill_ready_o);
      if (tv_miss_m) begin
        tracker_m = 1'b1;
      end else if (fill_done_i) begin
        tracker_m = 1'b0;
      end
      // a miss drops the fetch behind it
      tv_v     = tl_v & ~tv_miss_m;
      tv_addr  = tl_addr;
      tv_hit   = tl_hit;
      tv_way   = tl_way;
      tv_valid = tl_valid;
      tl_v     = accept_m;
      if (accept_m) begin
        tl_addr  = addr_i;
        tl_idx   = addr_i[11:6];
        tl_valid = model_valid[tl_idx];
        tl_hit   = 1'b0;
        tl_way   = '0;
        for (int w = icache_cfg_pkg::ways_lp - 1; w >= 0; w--) begin
          if (model_valid[tl_idx][w] && model_tag[tl_idx][w] == addr_i[31:12]) begin
            tl_hit = 1'b1;
            tl_way = icache_cfg_pkg::way_id_t'(w);
          end
        end
      end
      if (fill_v_i && !accept_m) begin
        case (fill_op_i)
          icache_msg_pkg::clear_set: begin
            model_valid[fill_index_i] = '0;
            model_lru[fill_index_i]   = '0;
          end
          icache_msg_pkg::set_tag: begin
            model_valid[fill_index_i][fill_way_i] = 1'b1;
            model_tag[fill_index_i][fill_way_i]   = fill_tag_i;
          end
          icache_msg_pkg::invalidate_way: begin
            model_valid[fill_index_i][fill_way_i] = 1'b0;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // entered on a falling edge, returns on one
  task automatic fill_cmd(input icache_msg_pkg::fill_op_e op, input icache_cfg_pkg::index_t index,
                          input icache_cfg_pkg::way_id_t way,
                          input icache_cfg_pkg::word_offset_t offset,
                          input icache_cfg_pkg::tag_t tag, input icache_cfg_pkg::dword_t data);
    fill_v_i      = 1'b1;
    fill_op_i     = op;
    fill_index_i  = index;
    fill_way_i    = way;
    fill_offset_i = offset;
    fill_tag_i    = tag;
    fill_data_i   = data;
    @(posedge clk_i);
    while (fill_ready_o !== 1'b1) @(posedge clk_i);
    @(negedge clk_i);
    fill_v_i = 1'b0;
  endtask

  // fill responder: random ready delay, tag, eight words, done pulse
  task automatic serve_miss();
    int                      delay;
    int                      n;
    icache_cfg_pkg::addr_t   line;
    icache_cfg_pkg::way_id_t way;
    n = 0;
    while (miss_req_v_o !== 1'b1 && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (miss_req_v_o !== 1'b1) begin
      report_failure("no miss request followed the miss");
      return;
    end
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(negedge clk_i);
    miss_req_ready_i = 1'b1;
    line = miss_req_addr_o;
    way  = miss_req_way_o;
    @(negedge clk_i);
    miss_req_ready_i = 1'b0;
    fill_cmd(icache_msg_pkg::set_tag, line[11:6], way, '0, line[31:12], '0);
    for (int o = 0; o < icache_cfg_pkg::words_per_line_lp; o++) begin
      fill_cmd(icache_msg_pkg::write_data, line[11:6], way, icache_cfg_pkg::word_offset_t'(o),
               '0, ref_word(line, icache_cfg_pkg::word_offset_t'(o)));
    end
    fill_done_i = 1'b1;
    @(negedge clk_i);
    fill_done_i = 1'b0;
  endtask

  // hold the fetch until it is accepted
  task automatic send_one(input icache_cfg_pkg::addr_t addr);
    int n;
    n = 0;
    addr_i   = addr;
    addr_v_i = 1'b1;
    @(posedge clk_i);
    while (addr_ready_o !== 1'b1 && n < 100) begin
      @(posedge clk_i);
      n++;
    end
    if (addr_ready_o !== 1'b1) begin
      report_failure("fetch was never accepted");
    end
    @(negedge clk_i);
    addr_v_i = 1'b0;
  endtask

  // re-send after each miss until the fetch hits
  task automatic fetch_hit(input icache_cfg_pkg::addr_t addr);
    logic got;
    logic seen_hit;
    logic seen_miss;
    int   n;
    got = 1'b0;
    for (int tries = 0; tries < 3 && !got; tries++) begin
      send_one(addr);
      seen_hit  = 1'b0;
      seen_miss = 1'b0;
      n = 0;
      while (!seen_hit && !seen_miss && n < 8) begin
        @(posedge clk_i);
        seen_hit  = (data_v_o === 1'b1);
        seen_miss = (miss_o === 1'b1);
        n++;
      end
      @(negedge clk_i);
      if (seen_hit) begin
        got = 1'b1;
      end else if (seen_miss) begin
        serve_miss();
      end else begin
        report_failure($sformatf("no result for fetch %h", addr));
      end
    end
    if (!got) begin
      report_failure($sformatf("fetch %h did not hit after its fill", addr));
    end
  endtask

  initial begin : stimulus
    seed             = 79;
    test_name        = "reset";
    reset_i          = 1'b1;
    addr_i           = '0;
    addr_v_i         = 1'b0;
    miss_req_ready_i = 1'b0;
    fill_v_i         = 1'b0;
    fill_op_i        = icache_msg_pkg::clear_set;
    fill_index_i     = '0;
    fill_way_i       = '0;
    fill_offset_i    = '0;
    fill_tag_i       = '0;
    fill_data_i      = '0;
    fill_done_i      = 1'b0;
    for (int i = 0; i < 9; i++) begin
      line_addr[i] = $random(seed) & ~32'h3;
    end
    // five tags into the set of line_addr[4]
    for (int j = 0; j < 5; j++) begin
      set_addr[j] = {line_addr[4 + j][31:12], line_addr[4][11:6], line_addr[4 + j][5:2], 2'b00};
    end
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "clear all sets";
    for (int s = 0; s < icache_cfg_pkg::sets_lp; s++) begin
      fill_cmd(icache_msg_pkg::clear_set, icache_cfg_pkg::index_t'(s), '0, '0, '0, '0);
    end

    test_name = "miss then fill";
    for (int i = 0; i < 4; i++) begin
      fetch_hit(line_addr[i]);
    end

    // second pass flips word and half within the same lines
    test_name = "back-to-back hits";
    for (int i = 0; i < 8; i++) begin
      send_one(line_addr[i % 4] ^ (i < 4 ? 32'h0 : 32'h24));
    end
    repeat (4) @(negedge clk_i);

    test_name = "replacement";
    for (int j = 0; j < 4; j++) begin
      fetch_hit(set_addr[j]);
    end
    fetch_hit(set_addr[0]);
    fetch_hit(set_addr[2]);
    fetch_hit(set_addr[4]);
    fetch_hit(set_addr[1]);

    test_name = "invalidate";
    fill_cmd(icache_msg_pkg::invalidate_way, set_addr[2][11:6], 2'd2, '0, '0, '0);
    repeat (2) @(negedge clk_i);
    fetch_hit(set_addr[2]);

    repeat (4) @(negedge clk_i);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (cycle_limit_lp) @(posedge clk_i);
    $display("timeout: run did not end within %0d cycles", cycle_limit_lp);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/icache_cfg_pkg.sv ====
/*
 * icache geometry
 * 4-way, 64 sets of 64-byte lines, 32-bit physical byte addresses.
 * Field widths and the types built from them.
 */
`default_nettype none

package icache_cfg_pkg;

  localparam int ways_lp           = 4;
  localparam int sets_lp           = 64;
  localparam int words_per_line_lp = 8;
  localparam int paddr_width_lp    = 32;
  localparam int dword_width_lp    = 64;
  localparam int instr_width_lp    = 32;

  // derived address fields
  localparam int byte_offset_width_lp  = $clog2(dword_width_lp / 8);
  localparam int word_offset_width_lp  = $clog2(words_per_line_lp);
  localparam int block_offset_width_lp = byte_offset_width_lp + word_offset_width_lp;
  localparam int index_width_lp        = $clog2(sets_lp);
  localparam int tag_width_lp          = paddr_width_lp - block_offset_width_lp - index_width_lp;
  localparam int way_id_width_lp       = $clog2(ways_lp);

  typedef logic [paddr_width_lp-1:0]       addr_t;
  typedef logic [tag_width_lp-1:0]         tag_t;
  typedef logic [index_width_lp-1:0]       index_t;
  typedef logic [word_offset_width_lp-1:0] word_offset_t;
  typedef logic [way_id_width_lp-1:0]      way_id_t;
  typedef logic [ways_lp-1:0]              ways_t;
  typedef logic [dword_width_lp-1:0]       dword_t;
  typedef logic [instr_width_lp-1:0]       instr_t;
  // tree bits, bit0 at the root
  typedef logic [ways_lp-2:0]              lru_t;

endpackage

`default_nettype wire

// ==== verilog/icache_data_array.sv ====
/*
 * icache data array
 * One row per line word holding that word for all four ways.
 * Lookups read a whole row; fills write one way's word.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_data_array (
  input  logic                         clk_i,
  input  logic                         lookup_v_i,
  input  icache_cfg_pkg::index_t       lookup_index_i,
  input  icache_cfg_pkg::word_offset_t lookup_offset_i,
  input  logic                         fill_we_i,
  input  icache_cfg_pkg::index_t       fill_index_i,
  input  icache_cfg_pkg::word_offset_t fill_offset_i,
  input  icache_cfg_pkg::way_id_t      fill_way_i,
  input  icache_cfg_pkg::dword_t       fill_data_i,
  output icache_cfg_pkg::dword_t [icache_cfg_pkg::ways_lp-1:0] words_o
);

  typedef icache_cfg_pkg::dword_t [icache_cfg_pkg::ways_lp-1:0] data_row_t;

  localparam int rows_lp = icache_cfg_pkg::sets_lp * icache_cfg_pkg::words_per_line_lp;

  logic                       mem_v;
  logic                       mem_w;
  logic [$clog2(rows_lp)-1:0] mem_addr;
  data_row_t                  wr_data;
  data_row_t                  wr_mask;

  assign mem_v    = lookup_v_i | fill_we_i;
  assign mem_w    = ~lookup_v_i & fill_we_i;
  assign mem_addr = lookup_v_i ? {lookup_index_i, lookup_offset_i}
                               : {fill_index_i, fill_offset_i};

  // same word on every way, mask picks the target
  assign wr_data  = {icache_cfg_pkg::ways_lp{fill_data_i}};

  always_comb begin
    for (int i = 0; i < icache_cfg_pkg::ways_lp; i++) begin
      wr_mask[i] = (fill_way_i == icache_cfg_pkg::way_id_t'(i)) ? '1 : '0;
    end
  end

  icache_sram #(
    .word_t(data_row_t),
    .els_p (rows_lp)
  ) data_mem_i (
    .clk_i   (clk_i),
    .v_i     (mem_v),
    .w_i     (mem_w),
    .addr_i  (mem_addr),
    .data_i  (wr_data),
    .w_mask_i(wr_mask),
    .data_o  (words_o)
  );

endmodule

`default_nettype wire

// ==== verilog/icache_lookup.sv ====
/*
 * icache lookup pipeline
 * TL holds the accepted address while the arrays read. TV compares
 * tags, picks the lowest hitting way and returns one instruction.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_lookup (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  icache_cfg_pkg::addr_t      addr_i,
  input  logic                       accept_i,
  input  icache_msg_pkg::tag_entry_t [icache_cfg_pkg::ways_lp-1:0] entries_i,
  input  icache_cfg_pkg::dword_t [icache_cfg_pkg::ways_lp-1:0]     words_i,
  output logic                       tv_v_o,
  output icache_cfg_pkg::addr_t      tv_addr_o,
  output logic                       hit_o,
  output icache_cfg_pkg::way_id_t    hit_way_o,
  output icache_cfg_pkg::ways_t      valid_ways_o,
  output icache_cfg_pkg::instr_t     data_o,
  output logic                       data_v_o,
  output logic                       miss_o
);

  logic                  tl_v_r;
  icache_cfg_pkg::addr_t tl_addr_r;

  logic                  tv_v_r;
  icache_cfg_pkg::addr_t tv_addr_r;
  icache_msg_pkg::tag_entry_t [icache_cfg_pkg::ways_lp-1:0] tv_entries_r;
  icache_cfg_pkg::dword_t [icache_cfg_pkg::ways_lp-1:0]     tv_words_r;

  icache_cfg_pkg::tag_t    tv_tag;
  icache_cfg_pkg::ways_t   hit_ways;
  icache_cfg_pkg::way_id_t hit_way;
  icache_cfg_pkg::dword_t  hit_word;
  logic                    any_hit;

  // TL stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= accept_i;
    end
    if (accept_i) begin
      tl_addr_r <= addr_i;
    end
  end

  // TV stage, a miss drops the fetch behind it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else begin
      tv_v_r <= tl_v_r & ~miss_o;
    end
    if (tl_v_r) begin
      tv_addr_r    <= tl_addr_r;
      tv_entries_r <= entries_i;
      tv_words_r   <= words_i;
    end
  end

  assign tv_tag = tv_addr_r[icache_cfg_pkg::paddr_width_lp-1 -: icache_cfg_pkg::tag_width_lp];

  always_comb begin
    for (int i = 0; i < icache_cfg_pkg::ways_lp; i++) begin
      valid_ways_o[i] = tv_entries_r[i].valid;
      hit_ways[i]     = tv_entries_r[i].valid & (tv_entries_r[i].tag == tv_tag);
    end
  end

  // lowest hitting way
  always_comb begin
    hit_way = '0;
    for (int i = icache_cfg_pkg::ways_lp - 1; i >= 0; i--) begin
      if (hit_ways[i]) begin
        hit_way = icache_cfg_pkg::way_id_t'(i);
      end
    end
  end

  assign any_hit  = |hit_ways;
  assign hit_word = tv_words_r[hit_way];

  assign tv_v_o    = tv_v_r;
  assign tv_addr_o = tv_addr_r;
  assign hit_o     = tv_v_r & any_hit;
  assign hit_way_o = hit_way;
  assign data_v_o  = tv_v_r & any_hit;
  assign miss_o    = tv_v_r & ~any_hit;

  // address bit 2 picks the upper half
  assign data_o = tv_addr_r[icache_cfg_pkg::byte_offset_width_lp-1]
    ? hit_word[icache_cfg_pkg::instr_width_lp +: icache_cfg_pkg::instr_width_lp]
    : hit_word[0 +: icache_cfg_pkg::instr_width_lp];

endmodule

`default_nettype wire

// ==== verilog/icache_miss_ctrl.sv ====
/*
 * icache miss control
 * Registers the miss request a cycle after the TV miss, holds it
 * under back-pressure, and blocks fetches until the fill is done.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_miss_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    miss_i,
  input  icache_cfg_pkg::addr_t   miss_addr_i,
  input  icache_cfg_pkg::way_id_t victim_way_i,
  input  logic                    fetch_v_i,
  input  logic                    miss_req_ready_i,
  input  logic                    fill_done_i,
  output icache_cfg_pkg::addr_t   miss_req_addr_o,
  output icache_cfg_pkg::way_id_t miss_req_way_o,
  output logic                    miss_req_v_o,
  output logic                    addr_ready_o
);

  localparam int line_bits_lp = icache_cfg_pkg::paddr_width_lp
                              - icache_cfg_pkg::block_offset_width_lp;

  logic tv_miss;
  logic tracker_r;

  // only a live TV fetch can miss
  assign tv_miss = fetch_v_i & miss_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_req_v_o <= 1'b0;
      tracker_r    <= 1'b0;
    end else begin
      if (tv_miss) begin
        miss_req_v_o <= 1'b1;
      end else if (miss_req_ready_i) begin
        miss_req_v_o <= 1'b0;
      end
      if (tv_miss) begin
        tracker_r <= 1'b1;
      end else if (fill_done_i) begin
        tracker_r <= 1'b0;
      end
    end
    if (tv_miss) begin
      // line-aligned address
      miss_req_addr_o <= {miss_addr_i[icache_cfg_pkg::paddr_width_lp-1 -: line_bits_lp],
                          {icache_cfg_pkg::block_offset_width_lp{1'b0}}};
      miss_req_way_o  <= victim_way_i;
    end
  end

  assign addr_ready_o = ~tracker_r & ~tv_miss;

endmodule

`default_nettype wire

// ==== verilog/icache_msg_pkg.sv ====
/*
 * icache fill messages
 * Fill command opcodes and the layout of one tag memory entry.
 */
`default_nettype none

package icache_msg_pkg;

  // fill commands from the miss handler
  typedef enum logic [1:0] {
    clear_set      = 2'd0,
    set_tag        = 2'd1,
    write_data     = 2'd2,
    invalidate_way = 2'd3
  } fill_op_e;

  // one way of a set, valid bit above the tag
  typedef struct packed {
    logic                valid;
    icache_cfg_pkg::tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== verilog/icache_replacement.sv ====
/*
 * icache replacement
 * Per-set pseudo-LRU tree bits in flops. Updated on TV hits,
 * zeroed by clear_set. Victim is the lowest invalid way, else the
 * way the tree points to.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_replacement (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  icache_cfg_pkg::index_t  tv_index_i,
  input  logic                    hit_i,
  input  icache_cfg_pkg::way_id_t hit_way_i,
  input  icache_cfg_pkg::ways_t   valid_ways_i,
  input  logic                    clear_v_i,
  input  icache_cfg_pkg::index_t  clear_index_i,
  output icache_cfg_pkg::way_id_t victim_way_o
);

  icache_cfg_pkg::lru_t    lru_r [icache_cfg_pkg::sets_lp];
  icache_cfg_pkg::lru_t    lru_tv;
  icache_cfg_pkg::lru_t    lru_hit;
  icache_cfg_pkg::way_id_t lru_way;
  icache_cfg_pkg::way_id_t invalid_way;

  assign lru_tv = lru_r[tv_index_i];

  // follow the pointers from the root
  assign lru_way = lru_tv[0] ? {1'b1, lru_tv[2]} : {1'b0, lru_tv[1]};

  // point the hit way's path away from it
  always_comb begin
    lru_hit    = lru_tv;
    lru_hit[0] = ~hit_way_i[1];
    if (hit_way_i[1]) begin
      lru_hit[2] = ~hit_way_i[0];
    end else begin
      lru_hit[1] = ~hit_way_i[0];
    end
  end

  // lowest invalid way
  always_comb begin
    invalid_way = '0;
    for (int i = icache_cfg_pkg::ways_lp - 1; i >= 0; i--) begin
      if (!valid_ways_i[i]) begin
        invalid_way = icache_cfg_pkg::way_id_t'(i);
      end
    end
  end

  assign victim_way_o = (&valid_ways_i) ? lru_way : invalid_way;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < icache_cfg_pkg::sets_lp; s++) begin
        lru_r[s] <= '0;
      end
    end else begin
      if (hit_i) begin
        lru_r[tv_index_i] <= lru_hit;
      end
      // a clear to the same set overrides the hit update
      if (clear_v_i) begin
        lru_r[clear_index_i] <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icache_sram.sv ====
/*
 * icache sram
 * Single-port synchronous memory, one cycle read latency,
 * bit-masked writes. Payload given by a type parameter.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_sram #(
  parameter type word_t = logic [63:0],
  parameter int  els_p  = 64
) (
  input  logic                     clk_i,
  input  logic                     v_i,
  input  logic                     w_i,
  input  logic [$clog2(els_p)-1:0] addr_i,
  input  word_t                    data_i,
  input  word_t                    w_mask_i,
  output word_t                    data_o
);

  word_t mem [els_p];

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        // merge new bits under the mask
        mem[addr_i] <= (data_i & w_mask_i) | (mem[addr_i] & ~w_mask_i);
      end else begin
        data_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icache_tag_array.sv ====
/*
 * icache tag array
 * Holds the four tag entries of each set. Lookup reads win over
 * fill commands; each fill opcode writes through its own mask.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      lookup_v_i,
  input  icache_cfg_pkg::index_t    lookup_index_i,
  input  logic                      fill_v_i,
  input  icache_msg_pkg::fill_op_e  fill_op_i,
  input  icache_cfg_pkg::index_t    fill_index_i,
  input  icache_cfg_pkg::way_id_t   fill_way_i,
  input  icache_cfg_pkg::tag_t      fill_tag_i,
  output icache_msg_pkg::tag_entry_t [icache_cfg_pkg::ways_lp-1:0] entries_o
);

  typedef icache_msg_pkg::tag_entry_t [icache_cfg_pkg::ways_lp-1:0] tag_set_t;

  logic                   mem_v;
  logic                   mem_w;
  icache_cfg_pkg::index_t mem_addr;
  tag_set_t               wr_data;
  tag_set_t               wr_mask;

  assign mem_v    = ~reset_i & (lookup_v_i | fill_v_i);
  // write_data commands belong to the data array
  assign mem_w    = ~lookup_v_i & fill_v_i & (fill_op_i != icache_msg_pkg::write_data);
  assign mem_addr = lookup_v_i ? lookup_index_i : fill_index_i;

  always_comb begin
    for (int i = 0; i < icache_cfg_pkg::ways_lp; i++) begin
      wr_data[i] = '0;
      wr_mask[i] = '0;
      case (fill_op_i)
        icache_msg_pkg::clear_set: begin
          wr_mask[i] = '1;
        end
        icache_msg_pkg::set_tag: begin
          wr_data[i].valid = 1'b1;
          wr_data[i].tag   = fill_tag_i;
          if (fill_way_i == icache_cfg_pkg::way_id_t'(i)) begin
            wr_mask[i] = '1;
          end
        end
        icache_msg_pkg::invalidate_way: begin
          // only the valid bit, tag is left as is
          wr_mask[i].valid = (fill_way_i == icache_cfg_pkg::way_id_t'(i));
        end
        default: begin
          wr_mask[i] = '0;
        end
      endcase
    end
  end

  icache_sram #(
    .word_t(tag_set_t),
    .els_p (icache_cfg_pkg::sets_lp)
  ) tag_mem_i (
    .clk_i   (clk_i),
    .v_i     (mem_v),
    .w_i     (mem_w),
    .addr_i  (mem_addr),
    .data_i  (wr_data),
    .w_mask_i(wr_mask),
    .data_o  (entries_o)
  );

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
/*
 * icache top
 * 4-way instruction cache: lookup pipeline, tag and data arrays,
 * pseudo-LRU replacement and miss control.
 */
`timescale 1ns/100ps
`default_nettype none

module icache_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  icache_cfg_pkg::addr_t        addr_i,
  input  logic                         addr_v_i,
  output logic                         addr_ready_o,
  output icache_cfg_pkg::instr_t       data_o,
  output logic                         data_v_o,
  output logic                         miss_o,
  output icache_cfg_pkg::addr_t        miss_req_addr_o,
  output icache_cfg_pkg::way_id_t      miss_req_way_o,
  output logic                         miss_req_v_o,
  input  logic                         miss_req_ready_i,
  input  logic                         fill_v_i,
  input  icache_msg_pkg::fill_op_e     fill_op_i,
  input  icache_cfg_pkg::index_t       fill_index_i,
  input  icache_cfg_pkg::way_id_t      fill_way_i,
  input  icache_cfg_pkg::word_offset_t fill_offset_i,
  input  icache_cfg_pkg::tag_t         fill_tag_i,
  input  icache_cfg_pkg::dword_t       fill_data_i,
  output logic                         fill_ready_o,
  input  logic                         fill_done_i
);

  logic                    accept;
  logic                    fill_go;
  icache_cfg_pkg::index_t  lookup_index;
  logic                    tv_v;
  icache_cfg_pkg::addr_t   tv_addr;
  logic                    hit;
  icache_cfg_pkg::way_id_t hit_way;
  icache_cfg_pkg::ways_t   valid_ways;
  icache_cfg_pkg::way_id_t victim_way;
  icache_msg_pkg::tag_entry_t [icache_cfg_pkg::ways_lp-1:0] entries;
  icache_cfg_pkg::dword_t [icache_cfg_pkg::ways_lp-1:0]     words;

  // lookups own both arrays on accept cycles
  assign accept       = addr_v_i & addr_ready_o;
  assign fill_ready_o = ~accept;
  assign fill_go      = fill_v_i & fill_ready_o;
  assign lookup_index = addr_i[icache_cfg_pkg::block_offset_width_lp +:
                               icache_cfg_pkg::index_width_lp];

  icache_lookup lookup_i (
    .clk_i, .reset_i, .addr_i, .accept_i(accept),
    .entries_i(entries), .words_i(words),
    .tv_v_o(tv_v), .tv_addr_o(tv_addr), .hit_o(hit), .hit_way_o(hit_way),
    .valid_ways_o(valid_ways), .data_o, .data_v_o, .miss_o
  );

  icache_tag_array tag_array_i (
    .clk_i, .reset_i, .lookup_v_i(accept), .lookup_index_i(lookup_index),
    .fill_v_i, .fill_op_i, .fill_index_i, .fill_way_i, .fill_tag_i,
    .entries_o(entries)
  );

  icache_data_array data_array_i (
    .clk_i, .lookup_v_i(accept), .lookup_index_i(lookup_index),
    .lookup_offset_i(addr_i[icache_cfg_pkg::byte_offset_width_lp +:
                            icache_cfg_pkg::word_offset_width_lp]),
    .fill_we_i(fill_v_i & (fill_op_i == icache_msg_pkg::write_data)),
    .fill_index_i, .fill_offset_i, .fill_way_i, .fill_data_i, .words_o(words)
  );

  icache_replacement replacement_i (
    .clk_i, .reset_i,
    .tv_index_i(tv_addr[icache_cfg_pkg::block_offset_width_lp +:
                        icache_cfg_pkg::index_width_lp]),
    .hit_i(hit), .hit_way_i(hit_way), .valid_ways_i(valid_ways),
    .clear_v_i(fill_go & (fill_op_i == icache_msg_pkg::clear_set)),
    .clear_index_i(fill_index_i), .victim_way_o(victim_way)
  );

  icache_miss_ctrl miss_ctrl_i (
    .clk_i, .reset_i, .miss_i(miss_o), .miss_addr_i(tv_addr),
    .victim_way_i(victim_way), .fetch_v_i(tv_v), .miss_req_ready_i, .fill_done_i,
    .miss_req_addr_o, .miss_req_way_o, .miss_req_v_o, .addr_ready_o
  );

endmodule

`default_nettype wire
